//--- ahbPkg.sv
// AHB bus widths, lane offset width, transfer type and transfer size enums
package ahbPkg;

        localparam int addrWidth       = 32;
        localparam int dataWidth       = 32;
        localparam int laneOffsetWidth = 2;     // Byte offset inside a word

        // Htrans encoding
        typedef enum logic [1:0]
        {
                Idle   = 2'b00,
                Busy   = 2'b01,
                Nonseq = 2'b10,
                Seq    = 2'b11
        } htransE;

        // Hsize encoding up to word
        typedef enum logic [2:0]
        {
                Byte = 3'b000,
                Half = 3'b001,
                Word = 3'b010
        } hsizeE;

endpackage

//--- apbPkg.sv
// APB slave count, slave region address map and bridge FSM state enum
package apbPkg;

        localparam int slaveCount = 4;

        // Haddr field that picks the region
        localparam int regionMsb = 31;
        localparam int regionLsb = 26;

        localparam logic [ahbPkg::addrWidth-1:0] regionBase0 = 32'h8000_0000; // Timer
        localparam logic [ahbPkg::addrWidth-1:0] regionBase1 = 32'h8400_0000; // Interrupt ctrl
        localparam logic [ahbPkg::addrWidth-1:0] regionBase2 = 32'h8800_0000; // Remap/pause
        localparam logic [ahbPkg::addrWidth-1:0] regionBase3 = 32'h8C00_0000; // Slave 4

        // Setup then enable, writes wait one cycle for Hwdata
        typedef enum logic [2:0]
        {
                StIdle    = 3'd0,
                StRead    = 3'd1,
                StRenable = 3'd2,
                StWwait   = 3'd3,
                StWrite   = 3'd4,
                StWenable = 3'd5
        } bridgeStateE;

endpackage

//--- xferIf.sv
// Accepted-transfer bundle from AHB decode to the APB sequencer and lane steering
interface xferIf;

        logic                           accept;         // Address phase taken this cycle
        logic [ahbPkg::addrWidth-1:0]   addr;
        logic                           write;
        ahbPkg::hsizeE                  size;
        logic [apbPkg::slaveCount-1:0]  sel;            // One-hot

        modport decode
        (
                output accept,
                output addr,
                output write,
                output size,
                output sel
        );

        modport exec
        (
                input  accept,
                input  addr,
                input  write,
                input  sel
        );

        modport result
        (
                input  addr,
                input  size
        );

endinterface

//--- ahbDecode.sv
// AHB address-phase decode, region select and accepted-transfer register
module ahbDecode
(
        input  logic                            Hclk,
        input  logic                            Hresetn,
        input  logic [ahbPkg::addrWidth-1:0]    Haddr,
        input  ahbPkg::htransE                  Htrans,
        input  logic                            Hwrite,
        input  ahbPkg::hsizeE                   Hsize,
        input  logic                            Hreadyout,
        xferIf.decode                           xfer
);

        logic [apbPkg::regionMsb-apbPkg::regionLsb:0]   regionField;
        logic [apbPkg::slaveCount-1:0]                  regionHit;
        logic                                           activeTrans;

        assign regionField = Haddr[apbPkg::regionMsb:apbPkg::regionLsb];

        // One compare per APB slave
        assign regionHit[0] = (regionField ==
                        apbPkg::regionBase0[apbPkg::regionMsb:apbPkg::regionLsb]);
        assign regionHit[1] = (regionField ==
                        apbPkg::regionBase1[apbPkg::regionMsb:apbPkg::regionLsb]);
        assign regionHit[2] = (regionField ==
                        apbPkg::regionBase2[apbPkg::regionMsb:apbPkg::regionLsb]);
        assign regionHit[3] = (regionField ==
                        apbPkg::regionBase3[apbPkg::regionMsb:apbPkg::regionLsb]);

        assign activeTrans = (Htrans == ahbPkg::Nonseq) || (Htrans == ahbPkg::Seq);

        // Idle, Busy and unmapped addresses never start an APB transfer
        assign xfer.accept = Hreadyout && activeTrans && (|regionHit);

        // Direction is needed in the accept cycle to pick read or write path
        assign xfer.write = Hwrite;

        always_ff @(posedge Hclk)
        begin
                if (xfer.accept)
                        xfer.addr <= Haddr;
        end

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        xfer.sel  <= '0;
                        xfer.size <= ahbPkg::Byte;
                end
                else if (xfer.accept)
                begin
                        xfer.sel  <= regionHit;
                        xfer.size <= Hsize;
                end
        end

endmodule

//--- apbSequencer.sv
// APB setup/enable state machine, APB control outputs and Hreadyout generation
module apbSequencer
(
        input  logic                            Hclk,
        input  logic                            Hresetn,
        xferIf.exec                             xfer,
        output logic                            Hreadyout,
        output logic [ahbPkg::addrWidth-1:0]    Paddr,
        output logic                            Pwrite,
        output logic                            Penable,
        output logic [apbPkg::slaveCount-1:0]   Pselx,
        output logic                            capture,
        output logic                            readPhase
);

        apbPkg::bridgeStateE    state;
        apbPkg::bridgeStateE    nextState;
        apbPkg::bridgeStateE    launch;
        logic                   apbActive;

        // Where a newly accepted transfer starts
        always_comb
        begin
                if (xfer.accept)
                        launch = xfer.write ? apbPkg::StWwait : apbPkg::StRead;
                else
                        launch = apbPkg::StIdle;
        end

        always_comb
        begin
                case (state)
                        apbPkg::StRead:
                                nextState = apbPkg::StRenable;
                        apbPkg::StWwait:
                                nextState = apbPkg::StWrite;   // Hwdata captured here
                        apbPkg::StWrite:
                                nextState = apbPkg::StWenable;
                        default:
                                nextState = launch;     // Idle or an enable phase
                endcase
        end

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        state     <= apbPkg::StIdle;
                        Hreadyout <= 1'b1;
                end
                else
                begin
                        state     <= nextState;
                        Hreadyout <= (nextState == apbPkg::StIdle) ||
                                     (nextState == apbPkg::StRenable) ||
                                     (nextState == apbPkg::StWenable);
                end
        end

        assign apbActive = (state == apbPkg::StRead) || (state == apbPkg::StRenable) ||
                           (state == apbPkg::StWrite) || (state == apbPkg::StWenable);

        // Decode register only reloads at the end of an enable phase
        assign Paddr   = xfer.addr;
        assign Pselx   = apbActive ? xfer.sel : '0;
        assign Pwrite  = (state == apbPkg::StWrite) || (state == apbPkg::StWenable);
        assign Penable = (state == apbPkg::StRenable) || (state == apbPkg::StWenable);

        assign capture   = (state == apbPkg::StWwait);
        assign readPhase = (state == apbPkg::StRenable);

endmodule

//--- laneSteer.sv
// Write-data capture and little-endian byte-lane steering for Pwdata and Hrdata
module laneSteer
(
        input  logic                            Hclk,
        input  logic                            Hresetn,
        xferIf.result                           xfer,
        input  logic                            capture,
        input  logic                            readPhase,
        input  logic [ahbPkg::dataWidth-1:0]    Hwdata,
        input  logic [ahbPkg::dataWidth-1:0]    Prdata,
        output logic [ahbPkg::dataWidth-1:0]    Pwdata,
        output logic [ahbPkg::dataWidth-1:0]    Hrdata
);

        logic [ahbPkg::dataWidth-1:0]           wdataReg;
        logic [ahbPkg::laneOffsetWidth-1:0]     offset;

        // Addressed lane moved down to bit 0, misaligned gives zero
        function automatic logic [ahbPkg::dataWidth-1:0] steer
        (
                input logic [ahbPkg::dataWidth-1:0]        data,
                input ahbPkg::hsizeE                       size,
                input logic [ahbPkg::laneOffsetWidth-1:0]  off
        );
                logic [ahbPkg::dataWidth-1:0] lane;

                lane = '0;
                case (size)
                        ahbPkg::Byte:
                                lane[7:0] = data[8*off +: 8];
                        ahbPkg::Half:
                        begin
                                if (!off[0])
                                        lane[15:0] = data[8*off +: 16];
                        end
                        ahbPkg::Word:
                        begin
                                if (off == '0)
                                        lane = data;
                        end
                        default:
                                lane = '0;
                endcase
                return lane;
        endfunction

        assign offset = xfer.addr[ahbPkg::laneOffsetWidth-1:0];

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                        wdataReg <= '0;
                else if (capture)
                        wdataReg <= Hwdata;     // Data phase of the accepted write
        end

        assign Pwdata = steer(wdataReg, xfer.size, offset);
        assign Hrdata = readPhase ? steer(Prdata, xfer.size, offset) : '0;

endmodule

//--- ahbApbBridge.sv
// AHB-to-APB bridge top level with AHB slave and APB master ports
module ahbApbBridge
(
        input  logic                            Hclk,
        input  logic                            Hresetn,
        input  logic [ahbPkg::addrWidth-1:0]    Haddr,
        input  ahbPkg::htransE                  Htrans,
        input  logic                            Hwrite,
        input  ahbPkg::hsizeE                   Hsize,
        input  logic [ahbPkg::dataWidth-1:0]    Hwdata,
        input  logic [ahbPkg::dataWidth-1:0]    Prdata,
        output logic                            Hreadyout,
        output logic [ahbPkg::dataWidth-1:0]    Hrdata,
        output logic [ahbPkg::addrWidth-1:0]    Paddr,
        output logic [ahbPkg::dataWidth-1:0]    Pwdata,
        output logic                            Pwrite,
        output logic                            Penable,
        output logic [apbPkg::slaveCount-1:0]   Pselx
);

        logic   capture;
        logic   readPhase;

        xferIf  xfer ();

        ahbDecode i_decode
        (
                .Hclk      (Hclk),
                .Hresetn   (Hresetn),
                .Haddr     (Haddr),
                .Htrans    (Htrans),
                .Hwrite    (Hwrite),
                .Hsize     (Hsize),
                .Hreadyout (Hreadyout),
                .xfer      (xfer.decode)
        );

        apbSequencer i_sequencer
        (
                .Hclk      (Hclk),
                .Hresetn   (Hresetn),
                .xfer      (xfer.exec),
                .Hreadyout (Hreadyout),
                .Paddr     (Paddr),
                .Pwrite    (Pwrite),
                .Penable   (Penable),
                .Pselx     (Pselx),
                .capture   (capture),
                .readPhase (readPhase)
        );

        laneSteer i_laneSteer
        (
                .Hclk      (Hclk),
                .Hresetn   (Hresetn),
                .xfer      (xfer.result),
                .capture   (capture),
                .readPhase (readPhase),
                .Hwdata    (Hwdata),
                .Prdata    (Prdata),
                .Pwdata    (Pwdata),
                .Hrdata    (Hrdata)
        );

endmodule

//--- tbClock.sv
// Testbench clock and power-on reset generator
module tbClock
(
        output logic    Hclk,
        output logic    Hresetn
);

        localparam int period      = 40;
        localparam int resetCycles = 2;

        initial
        begin
                Hclk = 1'b0;
                forever
                        #(period / 2) Hclk = ~Hclk;
        end

        initial
        begin
                Hresetn = 1'b0;
                #(period * resetCycles) Hresetn = 1'b1;        // Released on a falling edge
        end

endmodule

//--- ahbApbBridge_assert.sv
// APB protocol and reset assertions for the AHB-to-APB bridge top level
module ahbApbBridgeAssert
(
        input  logic                            Hclk,
        input  logic                            Hresetn,
        input  logic                            Hreadyout,
        input  logic                            Penable,
        input  logic [ahbPkg::addrWidth-1:0]    Paddr,
        input  logic [apbPkg::slaveCount-1:0]   Pselx
);

        int     assertFails = 0;

        // Enable phase only after a setup cycle to the same slave
        enableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
                $rose(Penable) |-> ((Pselx != '0) && (Pselx == $past(Pselx))))
        else
        begin
                $error("Penable rose without a setup cycle to the same slave");
                assertFails++;
        end

        selectOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn)
                $onehot0(Pselx))
        else
        begin
                $error("Pselx is not one-hot or zero");
                assertFails++;
        end

        // Setup is always followed by enable at the same address
        addrHeld: assert property (@(posedge Hclk) disable iff (!Hresetn)
                ((Pselx != '0) && !Penable) |=> (Penable && $stable(Paddr)))
        else
        begin
                $error("Paddr changed or Penable missing after the setup phase");
                assertFails++;
        end

        readyAfterReset: assert property (@(posedge Hclk)
                $rose(Hresetn) |-> Hreadyout)
        else
        begin
                $error("Hreadyout low in the first cycle after reset");
                assertFails++;
        end

endmodule

//--- ahbApbBridgeTb.sv
// Pattern-driven testbench for the AHB-to-APB bridge with AHB master and APB slave models
module ahbApbBridgeTb;

        localparam int clkPeriod = 40;

        typedef struct
        {
                logic                           write;
                logic                           chain;  // Sent in the enable cycle before
                logic [ahbPkg::addrWidth-1:0]   addr;
                ahbPkg::htransE                 trans;
                ahbPkg::hsizeE                  size;
                logic [ahbPkg::dataWidth-1:0]   wdata;
                logic [ahbPkg::dataWidth-1:0]   rdata;
                logic [apbPkg::slaveCount-1:0]  sel;    // Zero when the request is ignored
                logic [ahbPkg::dataWidth-1:0]   expData;
        } patternS;

        logic                           Hclk;
        logic                           Hresetn;
        logic [ahbPkg::addrWidth-1:0]   Haddr;
        ahbPkg::htransE                 Htrans;
        logic                           Hwrite;
        ahbPkg::hsizeE                  Hsize;
        logic [ahbPkg::dataWidth-1:0]   Hwdata;
        logic [ahbPkg::dataWidth-1:0]   Prdata;
        logic                           Hreadyout;
        logic [ahbPkg::dataWidth-1:0]   Hrdata;
        logic [ahbPkg::addrWidth-1:0]   Paddr;
        logic [ahbPkg::dataWidth-1:0]   Pwdata;
        logic                           Pwrite;
        logic                           Penable;
        logic [apbPkg::slaveCount-1:0]  Pselx;

        patternS        patterns[$];
        bit             loaded;
        bit             testBad;
        int             errorCount;
        int             testsFailed;

        tbClock i_clock
        (
                .Hclk    (Hclk),
                .Hresetn (Hresetn)
        );

        ahbApbBridge i_dut
        (
                .Hclk      (Hclk),
                .Hresetn   (Hresetn),
                .Haddr     (Haddr),
                .Htrans    (Htrans),
                .Hwrite    (Hwrite),
                .Hsize     (Hsize),
                .Hwdata    (Hwdata),
                .Prdata    (Prdata),
                .Hreadyout (Hreadyout),
                .Hrdata    (Hrdata),
                .Paddr     (Paddr),
                .Pwdata    (Pwdata),
                .Pwrite    (Pwrite),
                .Penable   (Penable),
                .Pselx     (Pselx)
        );

        bind ahbApbBridge ahbApbBridgeAssert i_assert
        (
                .Hclk      (Hclk),
                .Hresetn   (Hresetn),
                .Hreadyout (Hreadyout),
                .Penable   (Penable),
                .Paddr     (Paddr),
                .Pselx     (Pselx)
        );

        task automatic recordError;
                errorCount++;
                testBad = 1'b1;
        endtask

        task automatic checkSelect
        (
                input logic [apbPkg::slaveCount-1:0]    expSel,
                input logic [ahbPkg::addrWidth-1:0]     expAddr
        );
                if (Pselx !== expSel)
                begin
                        $display("Error: Pselx expected 0x%h, got 0x%h", expSel, Pselx);
                        recordError();
                end
                if (Paddr !== expAddr)
                begin
                        $display("Error: Paddr expected 0x%h, got 0x%h", expAddr, Paddr);
                        recordError();
                end
        endtask

        task automatic checkWrite
        (
                input logic [ahbPkg::dataWidth-1:0]     expData,
                input logic                             expWrite
        );
                if (Pwdata !== expData)
                begin
                        $display("Error: Pwdata expected 0x%h, got 0x%h", expData, Pwdata);
                        recordError();
                end
                if (Pwrite !== expWrite)
                begin
                        $display("Error: Pwrite expected 0x%h, got 0x%h", expWrite, Pwrite);
                        recordError();
                end
        endtask

        task automatic checkRead(input logic [ahbPkg::dataWidth-1:0] expData);
                if (Hrdata !== expData)
                begin
                        $display("Error: Hrdata expected 0x%h, got 0x%h", expData, Hrdata);
                        recordError();
                end
        endtask

        task automatic loadPatterns;
                int             fd;
                int             fields;
                string          line;
                logic [31:0]    f [9];
                patternS        p;

                fd = $fopen("bridgePatterns.txt", "r");
                if (fd != 0)
                begin
                        while (!$feof(fd))
                        begin
                                line = "";
                                void'($fgets(line, fd));
                                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                                 f[0], f[1], f[2], f[3], f[4],
                                                 f[5], f[6], f[7], f[8]);
                                if (fields == 9)        // Comment and blank lines fail here
                                begin
                                        p.write   = f[0][0];
                                        p.chain   = f[1][0];
                                        p.addr    = f[2];
                                        p.trans   = ahbPkg::htransE'(f[3][1:0]);
                                        p.size    = ahbPkg::hsizeE'(f[4][2:0]);
                                        p.wdata   = f[5];
                                        p.rdata   = f[6];
                                        p.sel     = f[7][apbPkg::slaveCount-1:0];
                                        p.expData = f[8];
                                        patterns.push_back(p);
                                end
                        end
                        $fclose(fd);
                end
        endtask

        // Starts and ends on a falling edge where Hreadyout is high
        task automatic runTransfer(input patternS p, input int idx);
                int     lowCycles;
                bit     lastWasSetup;
                bit     setupSeen;

                testBad      = 1'b0;
                lowCycles    = 0;
                lastWasSetup = 1'b0;
                setupSeen    = 1'b0;
                Haddr  = p.addr;
                Htrans = p.trans;
                Hwrite = p.write;
                Hsize  = p.size;
                @(posedge Hclk);
                @(negedge Hclk);
                Htrans = ahbPkg::Idle;                  // Nothing queued behind it
                Hwdata = p.write ? p.wdata : '0;
                Prdata = p.write ? '0 : p.rdata;        // Held through the enable phase
                if (p.sel == '0)
                begin
                        repeat (2)
                        begin
                                if (Hreadyout !== 1'b1)
                                begin
                                        $display("Error: Hreadyout expected 0x1, got 0x%h",
                                                 Hreadyout);
                                        recordError();
                                end
                                if (Pselx !== '0)
                                begin
                                        $display("Error: Pselx expected 0x0, got 0x%h", Pselx);
                                        recordError();
                                end
                                if (Penable !== 1'b0)
                                begin
                                        $display("Error: Penable expected 0x0, got 0x%h",
                                                 Penable);
                                        recordError();
                                end
                                @(negedge Hclk);
                        end
                end
                else
                begin
                        while (Hreadyout !== 1'b1)
                        begin
                                lastWasSetup = (Pselx != '0) && (Penable === 1'b0);
                                if (lastWasSetup)
                                begin
                                        setupSeen = 1'b1;
                                        checkSelect(p.sel, p.addr);
                                        if (p.write)
                                                checkWrite(p.expData, 1'b1);
                                end
                                lowCycles++;
                                @(negedge Hclk);
                        end
                        if (!setupSeen)
                        begin
                                $display("No APB setup phase was seen before Hreadyout rose");
                                recordError();
                        end
                        else if (!lastWasSetup || Penable !== 1'b1)
                        begin
                                $display("Penable did not follow the setup phase by one cycle");
                                recordError();
                        end
                        checkSelect(p.sel, p.addr);
                        if (p.write)
                                checkWrite(p.expData, 1'b1);
                        else
                        begin
                                if (Pwrite !== 1'b0)
                                begin
                                        $display("Error: Pwrite expected 0x0, got 0x%h", Pwrite);
                                        recordError();
                                end
                                checkRead(p.expData);
                        end
                        if (lowCycles != (p.write ? 2 : 1))
                        begin
                                $display("Hreadyout was low for %0d cycles instead of %0d",
                                         lowCycles, p.write ? 2 : 1);
                                recordError();
                        end
                end
                $display("Test %0d %s addr 0x%h %s", idx, p.write ? "write" : "read",
                         p.addr, testBad ? "failed" : "ok");
                if (testBad)
                        testsFailed++;
        endtask

        initial
        begin
                Haddr       = '0;
                Htrans      = ahbPkg::Idle;
                Hwrite      = 1'b0;
                Hsize       = ahbPkg::Word;
                Hwdata      = '0;
                Prdata      = '0;
                errorCount  = 0;
                testsFailed = 0;
                loaded      = 1'b0;
                loadPatterns();
                loaded = 1'b1;
                if (patterns.size() == 0)
                begin
                        $display("No patterns could be read from bridgePatterns.txt");
                        $display("Finished with errors");
                end
                else
                begin
                        @(posedge Hresetn);
                        @(posedge Hclk);
                        @(negedge Hclk);
                        foreach (patterns[i])
                        begin
                                if (!patterns[i].chain)
                                begin
                                        @(negedge Hclk);        // One idle cycle
                                        Prdata = '0;
                                end
                                runTransfer(patterns[i], i);
                        end
                        repeat (2) @(negedge Hclk);
                        $display("Tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                                 patterns.size(), testsFailed, errorCount,
                                 i_dut.i_assert.assertFails);
                        if (testsFailed == 0 && errorCount == 0 &&
                            i_dut.i_assert.assertFails == 0)
                                $display("Finished with no errors");
                        else
                                $display("Finished with errors");
                end
                $finish;
        end

        // Watchdog of about six cycles per transfer plus reset
        initial
        begin
                int limit;

                wait (loaded);
                limit = (patterns.size() * 6 + 10) * clkPeriod;
                #(limit);
                $display("Timeout: the DUT hung and gave no result within %0d time units", limit);
                $display("Finished with errors");
                $finish;
        end

endmodule

//--- bridgePatterns.txt
# op chain addr htrans size hwdata prdata expPselx expData, all hex, op 1 = write, chain 1 = sent in the enable cycle before
# htrans 0 Idle 2 Nonseq 3 Seq, size 0 byte 1 half 2 word, expData is Pwdata for writes and Hrdata for reads
# Word writes, one per region
1 0 80000010 2 2 11223344 00000000 1 11223344
1 0 84000124 3 2 a5a5f00f 00000000 2 a5a5f00f
1 0 88000008 2 2 deadbeef 00000000 4 deadbeef
1 0 8c0000fc 2 2 0badcafe 00000000 8 0badcafe
# Byte writes at every offset
1 0 80000000 2 0 8899aabb 00000000 1 000000bb
1 0 80000001 2 0 8899aabb 00000000 1 000000aa
1 0 80000002 2 0 8899aabb 00000000 1 00000099
1 0 80000003 2 0 8899aabb 00000000 1 00000088
# Halfword writes, then size and offset mismatches
1 0 84000040 2 1 7654fedc 00000000 2 0000fedc
1 0 84000042 2 1 7654fedc 00000000 2 00007654
1 0 88000001 2 1 7654fedc 00000000 4 00000000
1 0 8c000002 2 2 7654fedc 00000000 8 00000000
1 0 84000003 2 1 12345678 00000000 2 00000000
# Reads of every size
0 0 80000020 2 0 00000000 f1e2d3c4 1 000000c4
0 0 84000021 2 0 00000000 f1e2d3c4 2 000000d3
0 0 88000022 2 0 00000000 f1e2d3c4 4 000000e2
0 0 8c000023 2 0 00000000 f1e2d3c4 8 000000f1
0 0 80000030 2 1 00000000 a1b2c3d4 1 0000c3d4
0 0 80000032 3 1 00000000 a1b2c3d4 1 0000a1b2
0 0 84000034 2 2 00000000 5566aa99 2 5566aa99
0 0 88000036 2 2 00000000 5566aa99 4 00000000
# Ignored requests, unmapped addresses and Htrans Idle
1 0 90000000 2 2 ffffffff 00000000 0 00000000
0 0 40000010 2 2 00000000 12345678 0 00000000
1 0 80000040 0 2 ffffffff 00000000 0 00000000
0 0 84000000 0 2 00000000 87654321 0 00000000
# Overlapped transfers, each sent in the enable cycle before
0 0 80000050 2 2 00000000 13579bdf 1 13579bdf
1 1 84000060 2 2 2468ace0 00000000 2 2468ace0
0 1 88000071 3 0 00000000 0000ab00 4 000000ab
1 1 8c000076 2 1 beef0000 00000000 8 0000beef
0 1 80000078 2 2 00000000 cafef00d 1 cafef00d

//--- all.f
ahbPkg.sv
apbPkg.sv
xferIf.sv
ahbDecode.sv
apbSequencer.sv
laneSteer.sv
ahbApbBridge.sv
tbClock.sv
ahbApbBridge_assert.sv
ahbApbBridgeTb.sv

//--- Bender.yml
package:
  name: ahbApbBridge

sources:
  - ahbPkg.sv
  - apbPkg.sv
  - xferIf.sv
  - ahbDecode.sv
  - apbSequencer.sv
  - laneSteer.sv
  - ahbApbBridge.sv
  - target: test
    files:
      - tbClock.sv
      - ahbApbBridge_assert.sv
      - ahbApbBridgeTb.sv
